//--- design/qm_pkg.sv
// Queue manager shared definitions.
// Sizes of the queue, buffer and descriptor fields, the free list
// FSM encoding and the structs passed between the blocks and the bench.

`default_nettype none

package qm_pkg;

	localparam int NUM_QUEUES = 16;
	localparam int QID_NBITS = 4;

	localparam int NUM_BUFS = 32;
	localparam int BUF_NBITS = 5;
	localparam int DEPTH_NBITS = 6; // holds NUM_BUFS.

	localparam int PORT_NBITS = 3;
	localparam int LEN_NBITS = 11;
	localparam int TAG_NBITS = 8;

	localparam int ENQ_FIFO_DEPTH = 4;

	// free list startup FSM.
	localparam logic [1:0] FL_IDLE = 2'd0;
	localparam logic [1:0] FL_SWEEP = 2'd1;
	localparam logic [1:0] FL_DONE = 2'd2;

	typedef struct packed {
		logic [PORT_NBITS-1:0] src_port;
		logic [PORT_NBITS-1:0] dst_port;
		logic [LEN_NBITS-1:0] pkt_len;
		logic [TAG_NBITS-1:0] pkt_tag;
	} pkt_desc_t;

	typedef struct packed {
		logic [QID_NBITS-1:0] qid;
		pkt_desc_t desc;
	} enq_cmd_t;

	// to_empty: the queue held nothing before this enqueue.
	typedef struct packed {
		logic [QID_NBITS-1:0] qid;
		logic [PORT_NBITS-1:0] dst_port;
		logic to_empty;
	} enq_ack_t;

	// more: the queue still holds a descriptor after this dequeue.
	typedef struct packed {
		logic [QID_NBITS-1:0] qid;
		pkt_desc_t desc;
		logic more;
	} deq_ack_t;

endpackage

`default_nettype wire

//--- design/qm_enq_fifo.sv
// Enqueue latency FIFO.
// Parks enqueue commands while dequeues own the list; a pushed entry
// shows at the head the cycle after the push.

`default_nettype none
`timescale 1ns/1ps

module qm_enq_fifo (
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire qm_pkg::enq_cmd_t push_cmd,
	input wire pop,
	output logic empty,
	output qm_pkg::enq_cmd_t head_cmd
);
	import qm_pkg::*;

	enq_cmd_t mem [ENQ_FIFO_DEPTH];
	logic [$clog2(ENQ_FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(ENQ_FIFO_DEPTH)-1:0] rd_ptr;
	logic [$clog2(ENQ_FIFO_DEPTH):0] count;
	logic full;

	assign empty = (count == '0);
	assign full = (count == ENQ_FIFO_DEPTH);
	assign head_cmd = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_cmd;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == ENQ_FIFO_DEPTH-1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == ENQ_FIFO_DEPTH-1) ? '0 : rd_ptr + 1'b1;
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// a push on a full FIFO means too many enqueues outstanding.
	a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
	a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

`default_nettype wire

//--- design/qm_free_list.sv
// Free buffer list.
// A ring of buffer ids with head and tail pointers. After reset a sweep
// writes every id into its own slot, one per cycle, then raises init_done.

`default_nettype none
`timescale 1ns/1ps

module qm_free_list (
	input wire clk,
	input wire rst_n,
	input wire buf_get,
	input wire buf_put,
	input wire [qm_pkg::BUF_NBITS-1:0] put_id,
	output logic [qm_pkg::BUF_NBITS-1:0] free_head,
	output logic init_done
);
	import qm_pkg::*;

	logic [BUF_NBITS-1:0] ring [NUM_BUFS];
	logic [BUF_NBITS-1:0] hd_ptr;
	logic [BUF_NBITS-1:0] tl_ptr;
	logic [BUF_NBITS:0] count;
	logic [1:0] state;
	logic [1:0] state_nxt;
	logic sweep;
	logic fill;

	assign sweep = (state == FL_SWEEP);
	assign fill = sweep || buf_put; // both write at the tail.
	assign init_done = (state == FL_DONE);
	assign free_head = ring[hd_ptr];

	always_comb begin
		state_nxt = state;
		case (state)
			FL_IDLE: state_nxt = FL_SWEEP;
			FL_SWEEP: if (tl_ptr == BUF_NBITS'(NUM_BUFS-1)) state_nxt = FL_DONE;
			FL_DONE: state_nxt = FL_DONE;
			default: state_nxt = FL_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= FL_IDLE;
			hd_ptr <= '0;
			tl_ptr <= '0;
			count <= '0;
		end else begin
			state <= state_nxt;
			// pointers wrap on their own since NUM_BUFS is 2**BUF_NBITS.
			if (fill)
				tl_ptr <= tl_ptr + 1'b1;
			if (buf_get)
				hd_ptr <= hd_ptr + 1'b1;
			case ({fill, buf_get})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (sweep)
			ring[tl_ptr] <= tl_ptr; // id i lands in slot i.
		else if (buf_put)
			ring[tl_ptr] <= put_id;
	end

	// a get on an empty ring means more descriptors than buffers.
	a_get_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
		buf_get |-> count != '0);
	a_put_notfull: assert property (@(posedge clk) disable iff (!rst_n)
		buf_put |-> count != NUM_BUFS);

endmodule

`default_nettype wire

//--- design/qm_queue_table.sv
// Per-queue list state.
// Head, tail and depth for every queue, read combinationally at op_qid
// and updated at the edge that ends an enqueue or a dequeue.
// Depths are held at zero until the free list sweep is done.

`default_nettype none
`timescale 1ns/1ps

module qm_queue_table (
	input wire clk,
	input wire rst_n,
	input wire init_done,
	input wire op_enq,
	input wire op_deq,
	input wire [qm_pkg::QID_NBITS-1:0] op_qid,
	input wire [qm_pkg::BUF_NBITS-1:0] new_buf,
	input wire [qm_pkg::BUF_NBITS-1:0] next_of_head,
	output logic [qm_pkg::BUF_NBITS-1:0] q_head,
	output logic [qm_pkg::BUF_NBITS-1:0] q_tail,
	output logic [qm_pkg::DEPTH_NBITS-1:0] q_depth
);
	import qm_pkg::*;

	logic [BUF_NBITS-1:0] head_mem [NUM_QUEUES];
	logic [BUF_NBITS-1:0] tail_mem [NUM_QUEUES];
	logic [DEPTH_NBITS-1:0] depth_mem [NUM_QUEUES];
	logic q_empty;

	assign q_head = head_mem[op_qid];
	assign q_tail = tail_mem[op_qid];
	assign q_depth = depth_mem[op_qid];
	assign q_empty = (q_depth == '0);

	// depths clear until the sweep is done.
	always_ff @(posedge clk) begin
		if (!rst_n || !init_done) begin
			for (int i = 0; i < NUM_QUEUES; i++)
				depth_mem[i] <= '0;
		end else if (op_enq) begin
			depth_mem[op_qid] <= q_depth + 1'b1;
		end else if (op_deq) begin
			depth_mem[op_qid] <= q_depth - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (op_enq) begin
			tail_mem[op_qid] <= new_buf;
			if (q_empty)
				head_mem[op_qid] <= new_buf; // first entry is head and tail.
		end else if (op_deq) begin
			head_mem[op_qid] <= next_of_head;
		end
	end

	// a dequeue of an empty queue means the request came before its enqueue ack.
	a_deq_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
		op_deq |-> !q_empty);

	a_enq_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
		op_enq |-> q_depth != NUM_BUFS);

endmodule

`default_nettype wire

//--- design/qm_link_store.sv
// Link store.
// Per-buffer next pointer and descriptor arrays. An enqueue writes the
// descriptor at the new buffer and links it behind the old tail;
// both arrays are read at the queue head.

`default_nettype none
`timescale 1ns/1ps

module qm_link_store (
	input wire clk,
	input wire op_enq,
	input wire op_deq,
	input wire [qm_pkg::BUF_NBITS-1:0] new_buf,
	input wire qm_pkg::pkt_desc_t enq_desc,
	input wire [qm_pkg::BUF_NBITS-1:0] q_tail,
	input wire [qm_pkg::DEPTH_NBITS-1:0] q_depth,
	input wire [qm_pkg::BUF_NBITS-1:0] q_head,
	output logic [qm_pkg::BUF_NBITS-1:0] next_of_head,
	output qm_pkg::pkt_desc_t head_desc
);
	import qm_pkg::*;

	logic [BUF_NBITS-1:0] next_mem [NUM_BUFS];
	pkt_desc_t desc_mem [NUM_BUFS];

	always_ff @(posedge clk) begin
		if (op_enq) begin
			desc_mem[new_buf] <= enq_desc;
			// no link to write when the queue was empty.
			if (q_depth != '0)
				next_mem[q_tail] <= new_buf;
		end
	end

	assign next_of_head = next_mem[q_head];
	assign head_desc = desc_mem[q_head];

	// a head pointing at itself would be a corrupt list.
	a_no_self_link: assert property (@(posedge clk)
		op_deq && q_depth > 1 |-> next_of_head != q_head);

endmodule

`default_nettype wire

//--- design/qm_core.sv
// Queue manager control.
// Registers dequeue requests, grants the list to a dequeue ahead of a
// parked enqueue, drives one list operation per cycle and registers
// the enqueue and dequeue acks at the end of that cycle.

`default_nettype none
`timescale 1ns/1ps

module qm_core (
	input wire clk,
	input wire rst_n,
	input wire init_done,
	input wire enq_req,
	input wire qm_pkg::enq_cmd_t enq_cmd,
	input wire deq_req,
	input wire [qm_pkg::QID_NBITS-1:0] deq_qid,
	input wire [qm_pkg::DEPTH_NBITS-1:0] q_depth,
	input wire qm_pkg::pkt_desc_t head_desc,
	input wire [qm_pkg::BUF_NBITS-1:0] q_head,
	input wire [qm_pkg::BUF_NBITS-1:0] free_head,
	input wire fifo_empty,
	input wire qm_pkg::enq_cmd_t fifo_cmd,
	output logic fifo_pop,
	output logic op_enq,
	output logic op_deq,
	output logic [qm_pkg::QID_NBITS-1:0] op_qid,
	output logic buf_put,
	output qm_pkg::pkt_desc_t enq_desc,
	output logic ready,
	output logic enq_ack,
	output qm_pkg::enq_ack_t enq_info,
	output logic deq_ack,
	output qm_pkg::deq_ack_t deq_info
);
	import qm_pkg::*;

	logic deq_req_d1;
	logic [QID_NBITS-1:0] deq_qid_d1;

	always_ff @(posedge clk) begin
		if (!rst_n)
			deq_req_d1 <= 1'b0;
		else
			deq_req_d1 <= deq_req;
	end

	always_ff @(posedge clk)
		deq_qid_d1 <= deq_qid;

	// dequeue wins; a parked enqueue takes any other cycle.
	assign op_deq = deq_req_d1;
	assign fifo_pop = !deq_req_d1 && !fifo_empty;
	assign op_enq = fifo_pop;
	assign op_qid = deq_req_d1 ? deq_qid_d1 : fifo_cmd.qid;

	assign buf_put = op_deq; // head buffer goes back to the free list.
	assign enq_desc = fifo_cmd.desc;
	assign ready = init_done;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			enq_ack <= 1'b0;
			deq_ack <= 1'b0;
		end else begin
			enq_ack <= op_enq;
			deq_ack <= op_deq;
		end
	end

	// depth is sampled before this cycle's update.
	always_ff @(posedge clk) begin
		enq_info.qid <= fifo_cmd.qid;
		enq_info.dst_port <= fifo_cmd.desc.dst_port;
		enq_info.to_empty <= (q_depth == '0);
		deq_info.qid <= deq_qid_d1;
		deq_info.desc <= head_desc;
		deq_info.more <= (q_depth > 1);
	end

	a_req_after_ready: assert property (@(posedge clk) disable iff (!rst_n)
		enq_req || deq_req |-> init_done);

	a_enq_cmd_known: assert property (@(posedge clk) disable iff (!rst_n)
		enq_req |-> !$isunknown(enq_cmd));

	// a fresh buffer must never alias the live head of its queue.
	a_no_alias: assert property (@(posedge clk) disable iff (!rst_n)
		op_enq && q_depth != '0 |-> free_head != q_head);

endmodule

`default_nettype wire

//--- design/qm_top.sv
// Queue manager top level.
// Connects control, latency FIFO, free list, queue table and link store.

`default_nettype none
`timescale 1ns/1ps

module qm_top (
	input wire clk,
	input wire rst_n,
	input wire enq_req,
	input wire qm_pkg::enq_cmd_t enq_cmd,
	input wire deq_req,
	input wire [qm_pkg::QID_NBITS-1:0] deq_qid,
	output logic ready,
	output logic enq_ack,
	output qm_pkg::enq_ack_t enq_info,
	output logic deq_ack,
	output qm_pkg::deq_ack_t deq_info
);
	import qm_pkg::*;

	logic init_done;
	logic fifo_empty;
	logic fifo_pop;
	enq_cmd_t fifo_cmd;
	logic op_enq;
	logic op_deq;
	logic [QID_NBITS-1:0] op_qid;
	logic buf_put;
	logic [BUF_NBITS-1:0] free_head;
	logic [BUF_NBITS-1:0] q_head;
	logic [BUF_NBITS-1:0] q_tail;
	logic [DEPTH_NBITS-1:0] q_depth;
	logic [BUF_NBITS-1:0] next_of_head;
	pkt_desc_t enq_desc;
	pkt_desc_t head_desc;

	qm_core i_core (
		.clk(clk), .rst_n(rst_n), .init_done(init_done),
		.enq_req(enq_req), .enq_cmd(enq_cmd), .deq_req(deq_req), .deq_qid(deq_qid),
		.q_depth(q_depth), .head_desc(head_desc), .q_head(q_head), .free_head(free_head),
		.fifo_empty(fifo_empty), .fifo_cmd(fifo_cmd), .fifo_pop(fifo_pop),
		.op_enq(op_enq), .op_deq(op_deq), .op_qid(op_qid), .buf_put(buf_put),
		.enq_desc(enq_desc), .ready(ready), .enq_ack(enq_ack), .enq_info(enq_info),
		.deq_ack(deq_ack), .deq_info(deq_info)
	);

	qm_enq_fifo i_enq_fifo (
		.clk(clk), .rst_n(rst_n), .push(enq_req), .push_cmd(enq_cmd),
		.pop(fifo_pop), .empty(fifo_empty), .head_cmd(fifo_cmd)
	);

	qm_free_list i_free_list (
		.clk(clk), .rst_n(rst_n), .buf_get(op_enq), .buf_put(buf_put),
		.put_id(q_head), .free_head(free_head), .init_done(init_done)
	);

	qm_queue_table i_queue_table (
		.clk(clk), .rst_n(rst_n), .init_done(init_done), .op_enq(op_enq),
		.op_deq(op_deq), .op_qid(op_qid), .new_buf(free_head),
		.next_of_head(next_of_head), .q_head(q_head), .q_tail(q_tail), .q_depth(q_depth)
	);

	qm_link_store i_link_store (
		.clk(clk), .op_enq(op_enq), .op_deq(op_deq), .new_buf(free_head),
		.enq_desc(enq_desc), .q_tail(q_tail), .q_depth(q_depth), .q_head(q_head),
		.next_of_head(next_of_head), .head_desc(head_desc)
	);

endmodule

`default_nettype wire

//--- bench/qm_tb.sv
// Queue manager testbench.
// Drives random enqueues and dequeues through qm_top, keeps a per-queue
// model of the linked lists and checks every ack against it.

`default_nettype none
`timescale 1ns/1ps

module qm_tb;
	import qm_pkg::*;

	localparam int SEED = 86;
	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int FILL_ROUNDS = 4;
	localparam int RANDOM_CYCLES = 1500;
	localparam int TIMEOUT_CYCLES = 4000;

	logic clk = 1'b0;
	logic rst_n;
	logic enq_req;
	enq_cmd_t enq_cmd;
	logic deq_req;
	logic [QID_NBITS-1:0] deq_qid;
	logic ready;
	logic enq_ack;
	enq_ack_t enq_info;
	logic deq_ack;
	deq_ack_t deq_info;

	pkt_desc_t desc_q [NUM_QUEUES][$]; // descriptors linked in each queue.
	int deq_out [NUM_QUEUES]; // dequeues issued, not yet acked.
	enq_cmd_t pend_cmd [$];
	int pend_cyc [$];
	int deq_cyc [$];
	logic [QID_NBITS-1:0] deq_qq [$];
	int held;
	int cyc;
	int timeout_cnt = 0;
	int wait_cycles;

	always #(CLK_PERIOD/2) clk = ~clk;

	qm_top i_dut (
		.clk(clk), .rst_n(rst_n), .enq_req(enq_req), .enq_cmd(enq_cmd),
		.deq_req(deq_req), .deq_qid(deq_qid), .ready(ready), .enq_ack(enq_ack),
		.enq_info(enq_info), .deq_ack(deq_ack), .deq_info(deq_info)
	);

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic expect_equal(input string name, input logic [31:0] expv,
		input logic [31:0] actv);
		assert (expv === actv) else
			report_failure($sformatf("[FAIL] %s: expected %0h, actual %0h", name, expv, actv));
	endtask

	always @(posedge clk) begin
		timeout_cnt++;
		if (timeout_cnt >= TIMEOUT_CYCLES)
			report_failure("timeout: the run did not finish within the cycle limit");
	end

	// checks the acks at this negedge and updates the model.
	task automatic advance();
		enq_cmd_t exp_cmd;
		pkt_desc_t exp_desc;
		logic [QID_NBITS-1:0] qid;
		logic exp_deq;
		int depth;
		int enq_cyc;
		@(negedge clk);
		cyc++;
		exp_deq = (deq_cyc.size() != 0) && (deq_cyc[0] + 2 == cyc);
		expect_equal("deq_ack timing", exp_deq, deq_ack);
		if (enq_ack) begin
			assert (pend_cmd.size() != 0) else
				report_failure("enq_ack arrived with no enqueue outstanding");
			exp_cmd = pend_cmd.pop_front();
			enq_cyc = pend_cyc.pop_front();
			assert (cyc - enq_cyc >= 2) else
				report_failure("enq_ack arrived less than two cycles after its request");
			depth = desc_q[exp_cmd.qid].size();
			expect_equal("enq_ack qid", exp_cmd.qid, enq_info.qid);
			expect_equal("enq_ack dst_port", exp_cmd.desc.dst_port, enq_info.dst_port);
			expect_equal("enq_ack to_empty", depth == 0, enq_info.to_empty);
			desc_q[exp_cmd.qid].push_back(exp_cmd.desc);
			held++;
		end
		if (deq_ack) begin
			void'(deq_cyc.pop_front());
			qid = deq_qq.pop_front();
			depth = desc_q[qid].size();
			expect_equal("deq_ack qid", qid, deq_info.qid);
			exp_desc = desc_q[qid].pop_front();
			expect_equal("deq_ack desc", exp_desc, deq_info.desc);
			expect_equal("deq_ack more", depth > 1, deq_info.more);
			deq_out[qid]--;
			held--;
		end
	endtask

	function automatic bit can_enq();
		return pend_cmd.size() < ENQ_FIFO_DEPTH && held + pend_cmd.size() < NUM_BUFS;
	endfunction

	// first queue from a random start that has an acked descriptor left.
	function automatic bit pick_deq_queue(output logic [QID_NBITS-1:0] qid);
		int start;
		int q;
		start = $urandom_range(NUM_QUEUES-1, 0);
		for (int i = 0; i < NUM_QUEUES; i++) begin
			q = (start + i) % NUM_QUEUES;
			if (desc_q[q].size() > deq_out[q]) begin
				qid = q;
				return 1'b1;
			end
		end
		qid = '0;
		return 1'b0;
	endfunction

	task automatic idle_inputs();
		enq_req = 1'b0;
		deq_req = 1'b0;
	endtask

	task automatic issue_enq();
		enq_cmd_t cmd;
		cmd.qid = $urandom_range(NUM_QUEUES-1, 0);
		cmd.desc = $urandom;
		enq_req = 1'b1;
		enq_cmd = cmd;
		pend_cmd.push_back(cmd);
		pend_cyc.push_back(cyc);
	endtask

	task automatic issue_deq(input logic [QID_NBITS-1:0] qid);
		deq_req = 1'b1;
		deq_qid = qid;
		deq_out[qid]++;
		deq_cyc.push_back(cyc);
		deq_qq.push_back(qid);
	endtask

	task automatic drain_all();
		logic [QID_NBITS-1:0] qid;
		while (pend_cmd.size() != 0 || held != 0 || deq_cyc.size() != 0) begin
			advance();
			idle_inputs();
			if (pick_deq_queue(qid))
				issue_deq(qid);
		end
	endtask

	task automatic fill_and_drain();
		int issued;
		issued = 0;
		while (issued < NUM_BUFS) begin
			advance();
			idle_inputs();
			if (can_enq()) begin
				issue_enq();
				issued++;
			end
		end
		drain_all();
	endtask

	// enqueue weight swings every 200 cycles to reach full and empty lists.
	// an enqueue and a dequeue may share a cycle, so enqueues get parked.
	task automatic random_traffic();
		logic [QID_NBITS-1:0] qid;
		int weight;
		for (int n = 0; n < RANDOM_CYCLES; n++) begin
			advance();
			idle_inputs();
			weight = ((n / 200) % 2 == 0) ? 3 : 1;
			if ($urandom_range(3, 0) < weight && can_enq())
				issue_enq();
			if ($urandom_range(3, 0) >= weight && pick_deq_queue(qid))
				issue_deq(qid);
		end
	endtask

	initial begin
		void'($urandom(SEED));
		rst_n = 1'b0;
		enq_req = 1'b0;
		enq_cmd = '0;
		deq_req = 1'b0;
		deq_qid = '0;
		held = 0;
		cyc = 0;
		for (int q = 0; q < NUM_QUEUES; q++)
			deq_out[q] = 0;

		repeat (RESET_CYCLES) @(negedge clk);
		expect_equal("ready in reset", 1'b0, ready);
		rst_n = 1'b1;
		wait_cycles = 0;
		do begin
			@(negedge clk);
			wait_cycles++;
			expect_equal("enq_ack before first request", 1'b0, enq_ack);
			expect_equal("deq_ack before first request", 1'b0, deq_ack);
		end while (!ready);
		expect_equal("ready rise cycles", NUM_BUFS + 1, wait_cycles);

		repeat (FILL_ROUNDS) fill_and_drain();
		random_traffic();
		drain_all();
		repeat (4) begin
			advance();
			idle_inputs();
		end
		expect_equal("descriptors left", 0, held);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
design/qm_pkg.sv
design/qm_enq_fifo.sv
design/qm_free_list.sv
design/qm_queue_table.sv
design/qm_link_store.sv
design/qm_core.sv
design/qm_top.sv
bench/qm_tb.sv
